// ==== list.f ====
hdl/tnr_pkg.sv
hdl/pixel_diff.sv
hdl/restoring_divider.sv
hdl/blend_weight.sv
hdl/pixel_blend.sv
hdl/tnr_blend_top.sv
tb/tb_clock_gen.sv
tb/tnr_blend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TNR blender testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tnr_blend_tb -f list.f -o tnr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tnr_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== tb/tnr_blend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnr_blend_tb;

    localparam int pixel_max    = (1 << tnr_pkg::pixel_width) - 1;
    localparam int thr_max      = (1 << tnr_pkg::thr_width) - 1;
    localparam int reset_cycles = 2;
    // in_valid to out_valid, fixed by the pipeline
    localparam int latency      = 14;
    localparam int n_idle_start = 20;
    localparam int n_static     = 24;
    localparam int n_fast       = 24;
    localparam int n_band       = 64;
    localparam int n_burst      = 300;
    localparam int n_gap        = 40;
    localparam int max_gap      = 3;
    localparam int n_samples    = n_static + n_fast + n_band + n_burst + n_gap;
    // Every sample slot, every possible idle slot, drain and margin
    localparam int cycle_limit  = reset_cycles + n_idle_start + n_samples +
                                  n_gap * max_gap + latency + 100;

    logic                            clk;
    logic                            reset;
    logic                            in_valid;
    logic [tnr_pkg::pixel_width-1:0] cur;
    logic [tnr_pkg::pixel_width-1:0] prev;
    logic [tnr_pkg::thr_width-1:0]   blend_th0;
    logic [tnr_pkg::thr_width-1:0]   blend_th1;
    logic                            out_valid;
    logic [tnr_pkg::pixel_width-1:0] out_pixel;

    // Expected pixels and their input cycles, in issue order
    logic [tnr_pkg::pixel_width-1:0] exp_q[$];
    int                              in_cyc_q[$];
    int                              cyc = 0;

    tb_clock_gen #(
        .period_ns    (20),
        .reset_cycles (reset_cycles)
    ) i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    tnr_blend_top i_tnr_blend_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .cur       (cur),
        .prev      (prev),
        .blend_th0 (blend_th0),
        .blend_th1 (blend_th1),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    // Q8 weights, 256 is unity, w_s + w_f = 256
    function automatic logic [tnr_pkg::pixel_width-1:0] tnr_ref(
        input int c, input int p, input int t0, input int t1);
        int diff;
        int w_f;
        int w_s;
        int mix;
        diff = (c >= p) ? c - p : p - c;
        if (diff < t0) begin
            w_f = 0;
        end else if (t1 > t0 && diff <= t1) begin
            w_f = ((diff - t0) * 256) / (t1 - t0);
        end else begin
            w_f = 256;
        end
        w_s = 256 - w_f;
        // Round half up, then drop the fraction
        mix = (w_s * p + w_f * c + 128) >> 8;
        return tnr_pkg::pixel_width'(mix);
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    // Pixel pair with a given absolute difference, random order
    task automatic make_pair(input int diff, output int c, output int p);
        int base;
        base = $urandom_range(pixel_max - diff, 0);
        if ($urandom_range(1, 0) == 1) begin
            c = base + diff;
            p = base;
        end else begin
            c = base;
            p = base + diff;
        end
    endtask

    task automatic send_sample(input int c, input int p, input int t0, input int t1);
        @(negedge clk);
        in_valid  = 1'b1;
        cur       = tnr_pkg::pixel_width'(c);
        prev      = tnr_pkg::pixel_width'(p);
        blend_th0 = tnr_pkg::thr_width'(t0);
        blend_th1 = tnr_pkg::thr_width'(t1);
        exp_q.push_back(tnr_ref(c, p, t0, t1));
        in_cyc_q.push_back(cyc);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // Diff below th0, output follows prev
    task automatic static_region(input int n);
        int t0;
        int t1;
        int diff;
        int c;
        int p;
        for (int i = 0; i < n; i++) begin
            t0   = $urandom_range(thr_max, 1);
            t1   = $urandom_range(thr_max, 0);
            diff = $urandom_range(t0 - 1, 0);
            make_pair(diff, c, p);
            send_sample(c, p, t0, t1);
        end
    endtask

    // Above th1, then an unordered pair with diff at or over th0
    task automatic fast_region(input int n);
        int t0;
        int t1;
        int diff;
        int c;
        int p;
        for (int i = 0; i < n; i++) begin
            if (i < n / 2) begin
                t0 = $urandom_range(thr_max - 1, 0);
                t1 = $urandom_range(thr_max, t0 + 1);
                diff = (i % 4 == 0) ? t1 + 1 : int'($urandom_range(pixel_max, t1 + 1));
            end else begin
                t1 = $urandom_range(thr_max, 0);
                t0 = $urandom_range(thr_max, t1);
                diff = (i % 4 == 0) ? t0 : int'($urandom_range(pixel_max, t0));
            end
            make_pair(diff, c, p);
            send_sample(c, p, t0, t1);
        end
    endtask

    // Inside the band, both edges hit on purpose
    task automatic blend_region(input int n);
        int t0;
        int t1;
        int diff;
        int c;
        int p;
        for (int i = 0; i < n; i++) begin
            t0 = $urandom_range(thr_max - 1, 0);
            t1 = $urandom_range(thr_max, t0 + 1);
            case (i % 4)
                0: diff = t0;
                1: diff = t1;
                default: diff = $urandom_range(t1, t0);
            endcase
            make_pair(diff, c, p);
            send_sample(c, p, t0, t1);
        end
    endtask

    // Random thresholds per sample, diff spread across all classes
    task automatic random_sample();
        int t0;
        int t1;
        int diff;
        int c;
        int p;
        t0   = $urandom_range(thr_max, 0);
        t1   = $urandom_range(thr_max, 0);
        diff = $urandom_range(600, 0);
        make_pair(diff, c, p);
        send_sample(c, p, t0, t1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        in_valid  = 1'b0;
        cur       = '0;
        prev      = '0;
        blend_th0 = '0;
        blend_th1 = '0;
        void'($urandom(32'h7371_7856));
        wait (reset === 1'b0);
        // Quiet pipeline after reset
        idle_cycles(n_idle_start);
        static_region(n_static);
        fast_region(n_fast);
        blend_region(n_band);
        // Back to back, many in flight
        for (int i = 0; i < n_burst; i++) begin
            random_sample();
        end
        for (int i = 0; i < n_gap; i++) begin
            random_sample();
            idle_cycles($urandom_range(max_gap, 0));
        end
        idle_cycles(latency + 4);
        if (exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d samples never produced an output", exp_q.size());
            $display("Testbench failed");
            $fatal(1, "Unchecked samples at end of run");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare_output
        logic [tnr_pkg::pixel_width-1:0] exp_pixel;
        int                              in_cyc;
        if (out_valid === 1'b1) begin
            assert (exp_q.size() > 0) begin
                exp_pixel = exp_q.pop_front();
                in_cyc    = in_cyc_q.pop_front();
                // Fixed latency, so a late or early strobe is an error
                assert (cyc - in_cyc == latency) begin
                    assert (out_pixel === exp_pixel) else begin
                        $display("Error: out_pixel expected %h actual %h",
                                 exp_pixel, out_pixel);
                        $display("Testbench failed");
                        $fatal(1, "Output mismatch");
                    end
                end else begin
                    $display("Error: out_valid latency expected %h actual %h",
                             latency, cyc - in_cyc);
                    $display("Testbench failed");
                    $fatal(1, "Latency mismatch");
                end
            end else begin
                $display("out_valid was high with no sample pending at cycle %0d", cyc);
                $display("Testbench failed");
                $fatal(1, "Extra output");
            end
        end
    end

    // Strobe must be known once reset has taken effect
    always @(negedge clk) begin
        if (cyc >= 1) begin
            assert (!$isunknown(out_valid)) else begin
                $display("out_valid is unknown at cycle %0d", cyc);
                $display("Testbench failed");
                $fatal(1, "Unknown strobe");
            end
        end
    end

    always @(negedge clk) begin
        assert (cyc < cycle_limit) else begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    // Free running clock, low first
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset held over the first rising edges, dropped on a falling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/tnr_blend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnr_blend_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  logic [tnr_pkg::pixel_width-1:0] cur,
    input  logic [tnr_pkg::pixel_width-1:0] prev,
    input  logic [tnr_pkg::thr_width-1:0]   blend_th0,
    input  logic [tnr_pkg::thr_width-1:0]   blend_th1,
    output logic                            out_valid,
    output logic [tnr_pkg::pixel_width-1:0] out_pixel
);

    // Divider sized for a Q8 ratio of two threshold-wide values
    localparam int div_dividend_width = tnr_pkg::thr_width + tnr_pkg::frac_bits;
    localparam int div_divisor_width  = tnr_pkg::thr_width;

    logic                  diff_valid;
    tnr_pkg::diff_item_t   diff_item;
    logic                  weight_valid;
    tnr_pkg::weight_item_t weight_item;

    // 1 cycle, register and absolute difference
    pixel_diff i_pixel_diff (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .cur        (cur),
        .prev       (prev),
        .blend_th0  (blend_th0),
        .blend_th1  (blend_th1),
        .diff_valid (diff_valid),
        .diff_item  (diff_item)
    );

    // 11 cycles, classify, divide, select
    blend_weight #(
        .dividend_width (div_dividend_width),
        .divisor_width  (div_divisor_width)
    ) i_blend_weight (
        .clk          (clk),
        .reset        (reset),
        .diff_valid   (diff_valid),
        .diff_item    (diff_item),
        .weight_valid (weight_valid),
        .weight_item  (weight_item)
    );

    // 2 cycles, multiply then round
    pixel_blend i_pixel_blend (
        .clk          (clk),
        .reset        (reset),
        .weight_valid (weight_valid),
        .weight_item  (weight_item),
        .out_valid    (out_valid),
        .out_pixel    (out_pixel)
    );

endmodule

`default_nettype wire

// ==== hdl/pixel_blend.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_blend (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            weight_valid,
    input  tnr_pkg::weight_item_t           weight_item,
    output logic                            out_valid,
    output logic [tnr_pkg::pixel_width-1:0] out_pixel
);

    // Weight times pixel
    localparam int prod_width  = tnr_pkg::pixel_width + tnr_pkg::weight_width;
    // Half LSB of the Q8 result
    localparam int round_const = 1 << (tnr_pkg::frac_bits - 1);

    // Stage A, products
    logic                  mul_valid;
    logic [prod_width-1:0] prod_s;
    logic [prod_width-1:0] prod_f;

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_valid <= 1'b0;
        end else begin
            mul_valid <= weight_valid;
        end
    end

    always_ff @(posedge clk) begin
        prod_s <= weight_item.w_s * weight_item.prev;
        prod_f <= weight_item.w_f * weight_item.cur;
    end

    // Stage B, sum with rounding then drop fraction
    logic [prod_width:0] sum;

    assign sum = {1'b0, prod_s} + {1'b0, prod_f} + (prod_width + 1)'(round_const);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mul_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_pixel <= sum[tnr_pkg::frac_bits +: tnr_pkg::pixel_width];
    end

    // Convex mix stays inside the pixel pair it came from
    logic [tnr_pkg::pixel_width-1:0] pix_lo;
    logic [tnr_pkg::pixel_width-1:0] pix_hi;

    assign pix_lo = (weight_item.cur < weight_item.prev) ? weight_item.cur : weight_item.prev;
    assign pix_hi = (weight_item.cur < weight_item.prev) ? weight_item.prev : weight_item.cur;

    a_out_in_range : assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (out_pixel >= $past(pix_lo, 2)) && (out_pixel <= $past(pix_hi, 2)));

endmodule

`default_nettype wire

// ==== hdl/blend_weight.sv ====
`timescale 1ns/1ps
`default_nettype none

module blend_weight #(
    parameter int dividend_width = 17,
    parameter int divisor_width  = 9
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  diff_valid,
    input  tnr_pkg::diff_item_t   diff_item,
    output logic                  weight_valid,
    output tnr_pkg::weight_item_t weight_item
);

    // Q8 unity weight
    localparam logic [tnr_pkg::weight_width-1:0] full_weight =
        tnr_pkg::weight_width'(1 << tnr_pkg::frac_bits);

    //////////////////////////////////////////////////////////////////////
    // Stage 1, classify and form divider operands
    //////////////////////////////////////////////////////////////////////

    logic [tnr_pkg::pixel_width-1:0] th0_ext;
    logic [tnr_pkg::pixel_width-1:0] th1_ext;
    logic [tnr_pkg::pixel_width-1:0] diff_off;
    logic                            below_th0;
    logic                            in_band;
    logic [dividend_width-1:0]       dvd_d;
    logic [divisor_width-1:0]        dsr_d;
    tnr_pkg::weight_item_t           cls_d;

    always_comb begin
        th0_ext   = tnr_pkg::pixel_width'(diff_item.blend_th0);
        th1_ext   = tnr_pkg::pixel_width'(diff_item.blend_th1);
        below_th0 = diff_item.diff < th0_ext;
        // Band only exists for an ordered threshold pair, edges inclusive
        in_band   = (diff_item.blend_th1 > diff_item.blend_th0) && !below_th0 &&
                    (diff_item.diff <= th1_ext);
        diff_off  = diff_item.diff - th0_ext;

        // Class rides in the weight fields
        // w_s bit 0 flags blend, w_f holds the fixed motion weight
        cls_d.cur  = diff_item.cur;
        cls_d.prev = diff_item.prev;
        cls_d.w_s  = tnr_pkg::weight_width'(in_band);
        cls_d.w_f  = below_th0 ? '0 : full_weight;

        if (in_band) begin
            // (diff - th0) * 256 over (th1 - th0)
            dvd_d = dividend_width'(diff_off) << tnr_pkg::frac_bits;
            dsr_d = divisor_width'(diff_item.blend_th1 - diff_item.blend_th0);
        end else begin
            // Dummy 0 / 1 keeps the divider away from zero
            dvd_d = '0;
            dsr_d = divisor_width'(1);
        end
    end

    logic                      s1_valid;
    logic [dividend_width-1:0] s1_dvd;
    logic [divisor_width-1:0]  s1_dsr;
    tnr_pkg::weight_item_t     s1_cls;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= diff_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_dvd <= dvd_d;
        s1_dsr <= dsr_d;
        s1_cls <= cls_d;
    end

    //////////////////////////////////////////////////////////////////////
    // Division, nine stages
    //////////////////////////////////////////////////////////////////////

    logic                     div_done;
    logic [divisor_width-1:0] div_quot;
    tnr_pkg::weight_item_t    div_tag;

    restoring_divider #(
        .dividend_width (dividend_width),
        .divisor_width  (divisor_width)
    ) i_restoring_divider (
        .clk      (clk),
        .reset    (reset),
        .start    (s1_valid),
        .dividend (s1_dvd),
        .divisor  (s1_dsr),
        .tag      (s1_cls),
        .done     (div_done),
        .quotient (div_quot),
        .tag_out  (div_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // Final stage, weight select
    //////////////////////////////////////////////////////////////////////

    logic [tnr_pkg::weight_width-1:0] w_f_sel;

    // Quotient for blend samples, fixed weight otherwise
    assign w_f_sel = div_tag.w_s[0] ? tnr_pkg::weight_width'(div_quot) : div_tag.w_f;

    always_ff @(posedge clk) begin
        if (reset) begin
            weight_valid <= 1'b0;
        end else begin
            weight_valid <= div_done;
        end
    end

    always_ff @(posedge clk) begin
        weight_item.cur  <= div_tag.cur;
        weight_item.prev <= div_tag.prev;
        weight_item.w_f  <= w_f_sel;
        weight_item.w_s  <= full_weight - w_f_sel;
    end

    // Weights stay complementary, so the quotient never exceeded unity
    a_weight_sum : assert property (@(posedge clk) disable iff (reset)
        weight_valid |->
            ({1'b0, weight_item.w_s} + {1'b0, weight_item.w_f}) == {1'b0, full_weight});

endmodule

`default_nettype wire

// ==== hdl/restoring_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module restoring_divider #(
    parameter int dividend_width = 17,
    parameter int divisor_width  = 9
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic [dividend_width-1:0] dividend,
    input  logic [divisor_width-1:0]  divisor,
    input  tnr_pkg::weight_item_t     tag,
    output logic                      done,
    output logic [divisor_width-1:0]  quotient,
    output tnr_pkg::weight_item_t     tag_out
);

    // One quotient bit per stage
    localparam int quot_width = divisor_width;

    for (genvar i = 0; i < quot_width; i++) begin : g_stage
        logic                     vld_in;
        logic [divisor_width-1:0] rem_in;
        logic [quot_width-1:0]    low_in;
        logic [quot_width-1:0]    quot_in;
        logic [divisor_width-1:0] dsr_in;
        tnr_pkg::weight_item_t    tag_in;
        logic [divisor_width:0]   shifted;
        logic [divisor_width:0]   trial;
        logic                     borrow;
        logic                     vld_q;
        logic [quot_width-1:0]    quot_q;
        tnr_pkg::weight_item_t    tag_q;

        if (i == 0) begin : g_head
            // Upper dividend bits seed the remainder, must be below divisor
            assign vld_in  = start;
            assign rem_in  = divisor_width'(dividend >> quot_width);
            assign low_in  = dividend[quot_width-1:0];
            assign quot_in = '0;
            assign dsr_in  = divisor;
            assign tag_in  = tag;
        end else begin : g_body
            assign vld_in  = g_stage[i-1].vld_q;
            assign rem_in  = g_stage[i-1].g_carry.rem_q;
            assign low_in  = g_stage[i-1].g_carry.low_q;
            assign quot_in = g_stage[i-1].quot_q;
            assign dsr_in  = g_stage[i-1].g_carry.dsr_q;
            assign tag_in  = g_stage[i-1].tag_q;
        end

        // Bring down next dividend bit, then trial subtract
        assign shifted = {rem_in, low_in[quot_width-1]};
        assign trial   = shifted - {1'b0, dsr_in};
        assign borrow  = trial[divisor_width];

        always_ff @(posedge clk) begin
            if (reset) begin
                vld_q <= 1'b0;
            end else begin
                vld_q <= vld_in;
            end
        end

        // Quotient bit set when the trial did not borrow
        always_ff @(posedge clk) begin
            quot_q <= {quot_in[quot_width-2:0], ~borrow};
            tag_q  <= tag_in;
        end

        // Remainder and operands only needed by later stages
        if (i < quot_width - 1) begin : g_carry
            logic [divisor_width-1:0] rem_q;
            logic [quot_width-1:0]    low_q;
            logic [divisor_width-1:0] dsr_q;

            always_ff @(posedge clk) begin
                // Restore on borrow
                rem_q <= borrow ? shifted[divisor_width-1:0] : trial[divisor_width-1:0];
                low_q <= low_in << 1;
                dsr_q <= dsr_in;
            end
        end
    end

    assign done     = g_stage[quot_width-1].vld_q;
    assign quotient = g_stage[quot_width-1].quot_q;
    assign tag_out  = g_stage[quot_width-1].tag_q;

    // Caller must never start a division by zero
    a_divisor_nonzero : assert property (@(posedge clk) disable iff (reset)
        start |-> divisor != '0);

endmodule

`default_nettype wire

// ==== hdl/pixel_diff.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_diff (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  logic [tnr_pkg::pixel_width-1:0]   cur,
    input  logic [tnr_pkg::pixel_width-1:0]   prev,
    input  logic [tnr_pkg::thr_width-1:0]     blend_th0,
    input  logic [tnr_pkg::thr_width-1:0]     blend_th1,
    output logic                              diff_valid,
    output tnr_pkg::diff_item_t               diff_item
);

    // Absolute difference, larger minus smaller
    logic [tnr_pkg::pixel_width-1:0] abs_diff;
    logic                            cur_ge_prev;

    always_comb begin
        cur_ge_prev = cur >= prev;
        // Order the operands so the result never wraps
        if (cur_ge_prev) begin
            abs_diff = cur - prev;
        end else begin
            abs_diff = prev - cur;
        end
    end

    // Strobe register
    always_ff @(posedge clk) begin
        if (reset) begin
            diff_valid <= 1'b0;
        end else begin
            diff_valid <= in_valid;
        end
    end

    // Payload register, thresholds stay with their own pixel
    always_ff @(posedge clk) begin
        diff_item.cur       <= cur;
        diff_item.prev      <= prev;
        diff_item.diff      <= abs_diff;
        diff_item.blend_th0 <= blend_th0;
        diff_item.blend_th1 <= blend_th1;
    end

endmodule

`default_nettype wire

// ==== hdl/tnr_pkg.sv ====
`default_nettype none

package tnr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Pixel sample size
    localparam int pixel_width = 12;

    // Blend threshold size
    localparam int thr_width = 9;

    // Q8 weight, one extra bit so that 256 fits
    localparam int weight_width = 9;

    // Fractional bits of a weight
    localparam int frac_bits = 8;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    // Input side to weight stage
    typedef struct packed {
        logic [pixel_width-1:0] cur;
        logic [pixel_width-1:0] prev;
        logic [pixel_width-1:0] diff;
        logic [thr_width-1:0]   blend_th0;
        logic [thr_width-1:0]   blend_th1;
    } diff_item_t;

    // Weight stage to output side
    typedef struct packed {
        logic [pixel_width-1:0]  cur;
        logic [pixel_width-1:0]  prev;
        logic [weight_width-1:0] w_s;
        logic [weight_width-1:0] w_f;
    } weight_item_t;

endpackage

`default_nettype wire
